//--- lake_buffer.f
design/lake_cfg_pkg.sv
design/lake_mem_pkg.sv
design/access_ctrl.sv
design/agg_lane.sv
design/sram_stage.sv
design/lake_buffer.sv
sim/tb_clock.sv
sim/lake_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module lake_tb -f lake_buffer.f

sim:
	verilator --binary --timing --assert --top-module lake_tb -f lake_buffer.f -o lake_sim
	./obj_dir/lake_sim > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/lake_tb.sv
`timescale 1ns/1ps

module lake_tb;

  logic clk;
  logic rst_n;
  logic clk_en;
  logic flush;
  lake_mem_pkg::word_t [1:0] data_in;
  lake_cfg_pkg::access_cfg_t lane0_cfg;
  lake_cfg_pkg::access_cfg_t lane1_cfg;
  lake_cfg_pkg::edge_cfg_t edge_cfg;
  lake_cfg_pkg::access_cfg_t read_cfg;
  lake_mem_pkg::line_t data_out;
  logic out_valid;

  logic [31:0] lfsr = 32'h8fcd3901;
  string test_name = "reset";
  int errors = 0;
  int n_pass = 0;
  int n_fail = 0;
  int pulses = 0;
  bit recording = 0;
  lake_mem_pkg::line_t captured[$];
  lake_mem_pkg::line_t predicted[$];

  // model state per pattern with the lanes first, then transfer and read
  logic [15:0] m_cnt[4][3];
  logic [15:0] m_aoff[4];
  logic [15:0] m_soff[4];
  bit m_fin[4];
  logic [15:0] m_cc;
  logic [2:0] m_src;
  lake_mem_pkg::word_t m_agg[2][4];
  lake_mem_pkg::line_t m_sram[512];
  bit exp_valid;
  lake_mem_pkg::line_t exp_data;

  tb_clock clock_gen (.clk(clk));

  lake_buffer DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .clk_en    (clk_en),
    .flush     (flush),
    .data_in   (data_in),
    .lane0_cfg (lane0_cfg),
    .lane1_cfg (lane1_cfg),
    .edge_cfg  (edge_cfg),
    .read_cfg  (read_cfg),
    .data_out  (data_out),
    .out_valid (out_valid)
  );

  // galois lfsr stepped once per bit
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic lake_cfg_pkg::access_cfg_t get_cfg(input int p);
    case (p)
      0: return lane0_cfg;
      1: return lane1_cfg;
      2: return edge_cfg.pat;
      default: return read_cfg;
    endcase
  endfunction

  function automatic int count_fires(input lake_cfg_pkg::access_cfg_t c);
    int n;
    n = 1;
    for (int k = 0; k < c.dims; k++) begin
      n = n * (c.ranges[k] + 1);
    end
    return n;
  endfunction

  always @(posedge clk) begin : model
    lake_cfg_pkg::access_cfg_t c;
    bit f[4];
    bit rs[4];
    int lvl[4];
    logic [15:0] ad[4];
    lake_mem_pkg::line_t xline;
    logic [2:0] src;
    if (!rst_n) begin
      for (int p = 0; p < 4; p++) begin
        m_cnt[p] = '{default: '0};
        m_aoff[p] = '0;
        m_soff[p] = '0;
        m_fin[p] = 0;
      end
      m_cc = '0;
      m_src = '0;
      exp_valid = 0;
    end else begin
      assert (out_valid === exp_valid) else begin
        $display("Mismatch %s: out_valid expected %0b actual %0b", test_name, exp_valid,
                 out_valid);
        errors++;
      end
      if (out_valid && exp_valid) begin
        assert (data_out === exp_data) else begin
          $display("Mismatch %s: data_out expected %h actual %h", test_name, exp_data,
                   data_out);
          errors++;
        end
      end
      if (recording && exp_valid) predicted.push_back(exp_data);
      if (out_valid) begin
        pulses++;
        if (recording) captured.push_back(data_out);
      end
      for (int p = 0; p < 4; p++) begin
        c = get_cfg(p);
        lvl[p] = -1;
        for (int k = 0; k < 3; k++) begin
          if (k < c.dims && lvl[p] < 0 && m_cnt[p][k] != c.ranges[k]) lvl[p] = k;
        end
        rs[p] = (lvl[p] < 0);
        if (rs[p]) lvl[p] = 0;
        f[p] = clk_en && c.dims != 0 && !m_fin[p] && m_cc == c.sched_start + m_soff[p];
        ad[p] = c.addr_start + m_aoff[p];
      end
      if (clk_en) begin
        src = edge_cfg.src_start[2:0] + m_src;
        for (int j = 0; j < 4; j++) begin
          xline[j] = m_agg[src[2]][(src[1:0] + j) % 4];  // rotated aggregator read
        end
        if (f[3] && !f[2]) exp_data = m_sram[ad[3][8:0]];
        if (f[0]) m_agg[0][ad[0][1:0]] = data_in[0];
        if (f[1]) m_agg[1][ad[1][1:0]] = data_in[1];
        if (f[2]) m_sram[ad[2][8:0]] = xline;
        exp_valid = !flush && f[3] && !f[2];  // lost read on collision
        if (flush) begin
          for (int p = 0; p < 4; p++) begin
            m_cnt[p] = '{default: '0};
            m_aoff[p] = '0;
            m_soff[p] = '0;
            m_fin[p] = 0;
          end
          m_cc = '0;
          m_src = '0;
        end else begin
          if (f[2]) m_src = rs[2] ? 3'd0 : m_src + edge_cfg.src_strides[lvl[2]][2:0];
          for (int p = 0; p < 4; p++) begin
            c = get_cfg(p);
            if (f[p]) begin
              m_soff[p] = m_soff[p] + c.sched_strides[lvl[p]];
              m_aoff[p] = rs[p] ? 16'd0 : m_aoff[p] + c.addr_strides[lvl[p]];
              for (int k = 0; k < 3; k++) begin
                if (rs[p] || k < lvl[p]) m_cnt[p][k] = '0;
                else if (k == lvl[p]) m_cnt[p][k] = m_cnt[p][k] + 1'b1;
              end
            end
            if (c.dims == 0 || (f[p] && rs[p])) m_fin[p] = 1;
          end
          m_cc = m_cc + 1'b1;
        end
      end
    end
  end

  task automatic drive_data();
    data_in[0] <= rand_bits(16);
    data_in[1] <= rand_bits(16);
  endtask

  // lanes write four words at cycles 4 to 7
  task automatic lane_setup(input int dims);
    lake_cfg_pkg::access_cfg_t c;
    c = '0;
    c.dims = dims;
    c.ranges[0] = (dims == 1) ? 16'd3 : 16'd1;
    c.ranges[1] = (dims == 1) ? 16'd0 : 16'd1;
    c.addr_strides = {16'd1, 16'd1, 16'd1};
    c.sched_start = 16'd4;
    c.sched_strides = {16'd1, 16'd1, 16'd1};
    c.addr_start = rand_bits(2);
    lane0_cfg <= c;
    c.addr_start = rand_bits(2);
    lane1_cfg <= c;
  endtask

  task automatic random_setup(output int n_reads);
    lake_cfg_pkg::edge_cfg_t e;
    lake_cfg_pkg::access_cfg_t r;
    lane_setup(2);
    e = '0;
    e.pat.dims = 2 + rand_bits(1);
    for (int k = 0; k < e.pat.dims; k++) begin
      e.pat.ranges[k] = rand_bits(1);
      e.pat.addr_strides[k] = rand_bits(9);
      e.pat.sched_strides[k] = 1 + rand_bits(2);
      e.src_strides[k] = rand_bits(3);
    end
    e.pat.addr_start = rand_bits(9);
    e.pat.sched_start = 16'd12;
    e.src_start = rand_bits(3);
    r = e.pat;
    r.sched_start = 16'd52;  // after the last transfer
    edge_cfg <= e;
    read_cfg <= r;
    n_reads = count_fires(r);
  endtask

  task automatic run_round(input int stall_at, input int stall_len);
    int n;
    @(posedge clk);
    flush <= 1'b1;
    clk_en <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    drive_data();
    for (n = 0; n < 600; n++) begin
      @(negedge clk);
      if (m_fin[3]) break;
      @(posedge clk);
      clk_en <= !(n >= stall_at && n < stall_at + stall_len);
      drive_data();
    end
    if (n == 600) begin
      $display("%s: timed out waiting for the read pattern to finish", test_name);
      errors++;
    end
    repeat (3) begin
      @(posedge clk);
      clk_en <= 1'b1;
      drive_data();
    end
  endtask

  task automatic check_pulses(input int expected);
    assert (pulses == expected) else begin
      $display("Mismatch %s: valid pulses expected %0d actual %0d", test_name, expected,
               pulses);
      errors++;
    end
  endtask

  task automatic finish_test(input int err_before);
    if (errors == err_before) begin
      n_pass++;
      $display("test %s: passed", test_name);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", test_name, errors - err_before);
    end
  endtask

  initial begin
    lake_cfg_pkg::edge_cfg_t e;
    lake_cfg_pkg::access_cfg_t r;
    lake_mem_pkg::line_t first_run[$];
    logic [31:0] saved;
    int err0;
    int n_reads;
    rst_n = 1'b0;
    clk_en = 1'b0;
    flush = 1'b0;
    data_in = '0;
    lane0_cfg = '0;
    lane1_cfg = '0;
    edge_cfg = '0;
    read_cfg = '0;
    for (int a = 0; a < 512; a++) m_sram[a] = '0;
    m_agg = '{default: '0};
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    clk_en <= 1'b1;

    test_name = "reset_idle";
    err0 = errors;
    pulses = 0;
    repeat (100) @(posedge clk);
    check_pulses(0);
    finish_test(err0);

    test_name = "round_trip";
    err0 = errors;
    lane_setup(1);
    e = '0;
    e.pat.dims = 1;
    e.pat.ranges[0] = 16'd1;
    e.pat.addr_start = rand_bits(9);
    e.pat.addr_strides[0] = 1 + rand_bits(8);  // two distinct lines
    e.pat.sched_start = 16'd12;
    e.pat.sched_strides[0] = 16'd2;
    e.src_strides[0] = 16'd4;  // lane 0 then lane 1
    r = e.pat;
    r.sched_start = 16'd20;
    edge_cfg <= e;
    read_cfg <= r;
    pulses = 0;
    run_round(1000, 0);
    check_pulses(2);
    finish_test(err0);

    test_name = "random_patterns";
    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      random_setup(n_reads);
      pulses = 0;
      run_round(1000, 0);
      check_pulses(n_reads);
    end
    finish_test(err0);

    test_name = "write_wins";
    err0 = errors;
    lane_setup(1);
    r = e.pat;
    r.sched_start = 16'd14;  // first read meets the second transfer
    r.sched_strides[0] = 16'd4;
    edge_cfg <= e;
    read_cfg <= r;
    pulses = 0;
    run_round(1000, 0);
    check_pulses(1);
    finish_test(err0);

    test_name = "flush_restart";
    err0 = errors;
    random_setup(n_reads);
    saved = lfsr;
    captured.delete();
    predicted.delete();
    recording = 1;
    run_round(1000, 0);
    first_run = predicted;
    captured.delete();
    lfsr = saved;  // same data stream again
    run_round(1000, 0);
    recording = 0;
    assert (captured.size() == first_run.size()) else begin
      $display("Mismatch %s: line count expected %0d actual %0d", test_name,
               first_run.size(), captured.size());
      errors++;
    end
    for (int i = 0; i < captured.size() && i < first_run.size(); i++) begin
      assert (captured[i] === first_run[i]) else begin
        $display("Mismatch %s: line %0d expected %h actual %h", test_name, i, first_run[i],
                 captured[i]);
        errors++;
      end
    end
    finish_test(err0);

    test_name = "clk_en_stall";
    err0 = errors;
    for (int i = 0; i < 3; i++) begin
      random_setup(n_reads);
      pulses = 0;
      run_round(rand_bits(6), 1 + rand_bits(4));
      check_pulses(n_reads);
    end
    finish_test(err0);

    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real half_period = 2.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(half_period) clk = ~clk;  // 4 ns period

endmodule

//--- design/lake_buffer.sv
`timescale 1ns/1ps

module lake_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clk_en,
  input  logic                       flush,
  input  lake_mem_pkg::word_t [1:0]  data_in,
  input  lake_cfg_pkg::access_cfg_t  lane0_cfg,
  input  lake_cfg_pkg::access_cfg_t  lane1_cfg,
  input  lake_cfg_pkg::edge_cfg_t    edge_cfg,
  input  lake_cfg_pkg::access_cfg_t  read_cfg,
  output lake_mem_pkg::line_t        data_out,
  output logic                       out_valid
);

  logic [lake_cfg_pkg::cfg_width-1:0]       cycle_count;
  logic [lake_mem_pkg::agg_addr_width-1:0]  agg_rd_addr;
  lake_mem_pkg::line_t                      line0;
  lake_mem_pkg::line_t                      line1;

  // shared time base for every schedule
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_count <= '0;
    end else if (clk_en) begin
      if (flush) begin
        cycle_count <= '0;
      end else begin
        cycle_count <= cycle_count + 1'b1;
      end
    end
  end

  agg_lane lane0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (lane0_cfg),
    .word_in     (data_in[0]),
    .rd_addr     (agg_rd_addr),
    .line_out    (line0)
  );

  agg_lane lane1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (lane1_cfg),
    .word_in     (data_in[1]),
    .rd_addr     (agg_rd_addr),
    .line_out    (line1)
  );

  sram_stage sram (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .edge_cfg    (edge_cfg),
    .read_cfg    (read_cfg),
    .line0       (line0),
    .line1       (line1),
    .agg_rd_addr (agg_rd_addr),
    .data_out    (data_out),
    .out_valid   (out_valid)
  );

endmodule

//--- design/sram_stage.sv
`timescale 1ns/1ps

module sram_stage (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     clk_en,
  input  logic                                     flush,
  input  logic [lake_cfg_pkg::cfg_width-1:0]       cycle_count,
  input  lake_cfg_pkg::edge_cfg_t                  edge_cfg,
  input  lake_cfg_pkg::access_cfg_t                read_cfg,
  input  lake_mem_pkg::line_t                      line0,
  input  lake_mem_pkg::line_t                      line1,
  output logic [lake_mem_pkg::agg_addr_width-1:0]  agg_rd_addr,
  output lake_mem_pkg::line_t                      data_out,
  output logic                                     out_valid
);

  logic                                      xfer_fire;
  logic                                      xfer_restart;
  logic [lake_cfg_pkg::sel_width-1:0]        xfer_level;
  logic [lake_mem_pkg::sram_addr_width-1:0]  xfer_addr;
  logic                                      rd_fire;
  logic [lake_mem_pkg::sram_addr_width-1:0]  rd_addr;
  logic [lake_mem_pkg::agg_addr_width:0]     src_off;   // lane bit plus word offset
  logic [lake_mem_pkg::agg_addr_width:0]     src_addr;
  logic                                      lane_sel;
  lake_mem_pkg::line_t                       wr_line;
  lake_mem_pkg::line_t                       mem [lake_mem_pkg::sram_depth];

  access_ctrl #(
    .addr_width (lake_mem_pkg::sram_addr_width)
  ) xfer_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (edge_cfg.pat),
    .fire        (xfer_fire),
    .restart     (xfer_restart),
    .level       (xfer_level),
    .addr        (xfer_addr)
  );

  access_ctrl #(
    .addr_width (lake_mem_pkg::sram_addr_width)
  ) read_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (read_cfg),
    .fire        (rd_fire),
    .restart     (),
    .level       (),
    .addr        (rd_addr)
  );

  // aggregator read address follows the transfer nest
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_off <= '0;
    end else if (clk_en) begin
      if (flush || (xfer_fire && xfer_restart)) begin
        src_off <= '0;
      end else if (xfer_fire) begin
        src_off <= src_off + edge_cfg.src_strides[xfer_level][lake_mem_pkg::agg_addr_width:0];
      end
    end
  end

  assign src_addr = edge_cfg.src_start[lake_mem_pkg::agg_addr_width:0] + src_off;
  assign lane_sel = src_addr[lake_mem_pkg::agg_addr_width];
  assign agg_rd_addr = src_addr[lake_mem_pkg::agg_addr_width-1:0];
  assign wr_line = lane_sel ? line1 : line0;

  always_ff @(posedge clk) begin
    if (xfer_fire) begin
      mem[xfer_addr] <= wr_line;
    end else if (rd_fire) begin
      data_out <= mem[rd_addr];  // write wins the single port
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (clk_en) begin
      out_valid <= !flush && rd_fire && !xfer_fire;
    end
  end

  // a valid line comes from an SRAM entry that was written
  valid_line_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(data_out)
  );

endmodule

//--- design/agg_lane.sv
`timescale 1ns/1ps

module agg_lane (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     clk_en,
  input  logic                                     flush,
  input  logic [lake_cfg_pkg::cfg_width-1:0]       cycle_count,
  input  lake_cfg_pkg::access_cfg_t                cfg,
  input  lake_mem_pkg::word_t                      word_in,
  input  logic [lake_mem_pkg::agg_addr_width-1:0]  rd_addr,
  output lake_mem_pkg::line_t                      line_out
);

  logic                                     wr_fire;
  logic [lake_mem_pkg::agg_addr_width-1:0]  wr_addr;
  lake_mem_pkg::word_t                      regs [lake_mem_pkg::agg_depth];

  access_ctrl #(
    .addr_width (lake_mem_pkg::agg_addr_width)
  ) wr_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (cfg),
    .fire        (wr_fire),
    .restart     (),
    .level       (),
    .addr        (wr_addr)
  );

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      regs[wr_addr] <= word_in;
    end
  end

  // rotated line, wraps mod 4
  always_comb begin
    logic [lake_mem_pkg::agg_addr_width-1:0] idx;
    idx = rd_addr;
    for (int i = 0; i < lake_mem_pkg::line_words; i++) begin
      line_out[i] = regs[idx];
      idx = idx + 1'b1;
    end
  end

  word_known_on_fire: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_fire |-> !$isunknown(word_in)
  );

endmodule

//--- design/access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl #(
  parameter int addr_width = 9
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                clk_en,
  input  logic                                flush,
  input  logic [lake_cfg_pkg::cfg_width-1:0]  cycle_count,
  input  lake_cfg_pkg::access_cfg_t           cfg,
  output logic                                fire,
  output logic                                restart,
  output logic [lake_cfg_pkg::sel_width-1:0]  level,
  output logic [addr_width-1:0]               addr
);

  logic [lake_cfg_pkg::loop_dims-1:0][lake_cfg_pkg::cfg_width-1:0] cnt;
  logic [lake_cfg_pkg::loop_dims-1:0] maxed;
  logic [addr_width-1:0]              addr_off;
  logic [lake_cfg_pkg::cfg_width-1:0] sched_off;
  logic [lake_cfg_pkg::cfg_width-1:0] sched_addr;
  logic                               active;
  logic                               finished;

  always_comb begin
    for (int k = 0; k < lake_cfg_pkg::loop_dims; k++) begin
      maxed[k] = (cnt[k] == cfg.ranges[k]);
    end
  end

  // lowest active level that has not reached its range
  always_comb begin
    logic found;
    found = 1'b0;
    level = '0;
    for (int k = 0; k < lake_cfg_pkg::loop_dims; k++) begin
      if (!found && (k < cfg.dims) && !maxed[k]) begin
        level = k[lake_cfg_pkg::sel_width-1:0];
        found = 1'b1;
      end
    end
    restart = !found;  // every active level at range
  end

  assign active = (cfg.dims != '0);
  assign sched_addr = cfg.sched_start + sched_off;
  assign fire = clk_en && active && !finished && (cycle_count == sched_addr);
  assign addr = cfg.addr_start[addr_width-1:0] + addr_off;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
      addr_off <= '0;
      sched_off <= '0;
      finished <= 1'b0;
    end else if (clk_en) begin
      if (flush) begin
        cnt <= '0;
        addr_off <= '0;
        sched_off <= '0;
        finished <= 1'b0;
      end else begin
        if (fire) begin
          sched_off <= sched_off + cfg.sched_strides[level];
          if (restart) begin
            addr_off <= '0;
          end else begin
            addr_off <= addr_off + cfg.addr_strides[level][addr_width-1:0];
          end
          for (int k = 0; k < lake_cfg_pkg::loop_dims; k++) begin
            if (restart || (k < level)) begin
              cnt[k] <= '0;  // inner levels wrap
            end else if (k == level) begin
              cnt[k] <= cnt[k] + 1'b1;
            end
          end
        end
        if (!active || (fire && restart)) begin
          finished <= 1'b1;  // last fire, or idle pattern
        end
      end
    end
  end

  // a firing nest only uses levels that the hardware has
  level_in_nest: assert property (
    @(posedge clk) disable iff (!rst_n)
    fire |-> (level < cfg.dims) && (cfg.dims <= lake_cfg_pkg::loop_dims)
  );

endmodule

//--- design/lake_mem_pkg.sv
package lake_mem_pkg;

  localparam int word_width = 16;
  localparam int line_words = 4;    // words moved per SRAM access
  localparam int agg_depth = 4;
  localparam int sram_depth = 512;
  localparam int agg_addr_width = 2;
  localparam int sram_addr_width = 9;

  typedef logic [word_width-1:0] word_t;

  // word 0 sits in the low bits
  typedef word_t [line_words-1:0] line_t;

endpackage

//--- design/lake_cfg_pkg.sv
package lake_cfg_pkg;

  localparam int loop_dims = 3;   // levels per loop nest, 0 is innermost
  localparam int cfg_width = 16;  // range, start and stride fields
  localparam int dim_width = 4;
  localparam int sel_width = 2;   // wide enough to name any level

  // one access pattern: loop nest, address generator and schedule
  typedef struct packed {
    logic [dim_width-1:0]                dims;           // active levels, 0 = idle
    logic [loop_dims-1:0][cfg_width-1:0] ranges;         // iteration count minus one
    logic [cfg_width-1:0]                addr_start;
    logic [loop_dims-1:0][cfg_width-1:0] addr_strides;
    logic [cfg_width-1:0]                sched_start;    // first firing cycle
    logic [loop_dims-1:0][cfg_width-1:0] sched_strides;
  } access_cfg_t;

  // aggregator to SRAM transfer
  // pat drives the nest, the schedule and the SRAM write address
  typedef struct packed {
    access_cfg_t                         pat;
    logic [cfg_width-1:0]                src_start;      // bit 2 picks the lane
    logic [loop_dims-1:0][cfg_width-1:0] src_strides;
  } edge_cfg_t;

endpackage
